// File: source/arb_pkg.sv
// Arbitration size package
`default_nettype none

package arb_pkg;

  // Number of request sources that share the FIFO.
  localparam int NUM_SRC = 4;

  // Bits needed to name one source.
  localparam int SRC_IDX_W = $clog2(NUM_SRC);

  // Index of a single source, used for grants and records.
  typedef logic [SRC_IDX_W-1:0] src_idx_t;

endpackage

`default_nettype wire

// File: source/pkt_pkg.sv
// Payload and record package
`default_nettype none

package pkt_pkg;

  import arb_pkg::*;

  // Width of one source payload.
  localparam int PAYLOAD_W = 8;

  // One byte of payload carried per request.
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Record stored in the FIFO for every grant.
  typedef struct packed {
    src_idx_t src;      // Source that won the grant.
    payload_t payload;  // Payload it was holding.
  } grant_rec_t;

  // Number of records the FIFO can hold.
  localparam int FIFO_DEPTH = 8;

  // Read and write pointer width.
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// File: source/circular_xbar.sv
// Circular request rotator
`timescale 1ns/1ps
`default_nettype none

module circular_xbar
  import arb_pkg::*;
(
  input  src_idx_t           s_i,  // Amount of rotation.
  input  logic [NUM_SRC-1:0] i_i,  // Request vector in source order.
  output logic [NUM_SRC-1:0] o_o   // Request vector starting at source s_i.
);

  // Bit j of the output takes the request of source (j + s_i) mod NUM_SRC.
  // The source named by s_i therefore lands at position zero.
  always_comb begin
    for (int j = 0; j < NUM_SRC; j++) begin
      o_o[j] = i_i[(j + int'(s_i)) % NUM_SRC];  // Wrap around the top.
    end
  end

endmodule

`default_nettype wire

// File: source/fixed_priority_arbiter.sv
// Fixed priority picker
`timescale 1ns/1ps
`default_nettype none

module fixed_priority_arbiter
  import arb_pkg::*;
(
  input  logic               allow_req_i,      // Grants may be issued this cycle.
  input  logic [NUM_SRC-1:0] req_i,            // Active requests.
  output src_idx_t           gnt_addr_o,       // Lowest active request.
  output logic               gnt_addr_valid_o  // A grant is being issued.
);

  // Scan from the top down so the lowest set bit is the last one written.
  always_comb begin
    gnt_addr_o = '0;  // Index is a don't care when nothing is requested.
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        gnt_addr_o = src_idx_t'(i);  // Lower bits override higher ones.
      end
    end
  end

  // A grant needs both permission and at least one request.
  assign gnt_addr_valid_o = allow_req_i & (|req_i);

endmodule

`default_nettype wire

// File: source/round_robin_arbiter.sv
// Round robin arbiter
`timescale 1ns/1ps
`default_nettype none

module round_robin_arbiter
  import arb_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_ni,
  input  logic               allow_req_i,      // Downstream can take a grant.
  input  logic [NUM_SRC-1:0] req_i,            // Pending requests.
  output src_idx_t           gnt_addr_o,       // Granted source.
  output logic               gnt_addr_valid_o  // Grant is issued this cycle.
);

  src_idx_t             last_gnt;      // Source granted most recently.
  src_idx_t             next_gnt;      // Source with top priority now.
  logic [NUM_SRC-1:0]   rot_req;       // Requests rotated so next_gnt is bit zero.
  src_idx_t             rot_gnt_addr;  // Winner in rotated numbering.
  logic                 fpa_valid;     // Picker found a request.
  logic [SRC_IDX_W:0]   gnt_sum;       // Rotated winner plus offset with room for the carry.

  // Priority starts one past the last winner and wraps at NUM_SRC.
  assign next_gnt = (last_gnt == src_idx_t'(NUM_SRC - 1)) ? '0 : last_gnt + 1'b1;

  circular_xbar u_xbar (
    .s_i(next_gnt),
    .i_i(req_i),
    .o_o(rot_req)
  );

  fixed_priority_arbiter u_fpa (
    .allow_req_i     (allow_req_i),
    .req_i           (rot_req),
    .gnt_addr_o      (rot_gnt_addr),
    .gnt_addr_valid_o(fpa_valid)
  );

  // Undo the rotation by adding the offset back modulo NUM_SRC.
  assign gnt_sum = {1'b0, rot_gnt_addr} + {1'b0, next_gnt};
  assign gnt_addr_o = (gnt_sum >= (SRC_IDX_W + 1)'(NUM_SRC)) ?
                      src_idx_t'(gnt_sum - (SRC_IDX_W + 1)'(NUM_SRC)) : src_idx_t'(gnt_sum);

  // No grant leaves the arbiter while reset is asserted.
  assign gnt_addr_valid_o = fpa_valid & arst_ni;

  // After reset the last grant points at the top source, so source 0 wins first.
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      last_gnt <= src_idx_t'(NUM_SRC - 1);
    end else if (gnt_addr_valid_o) begin
      last_gnt <= gnt_addr_o;  // Remember the winner for the next round.
    end
  end

  // The rotate, pick and unrotate path must land on a real request.
  a_gnt_hits_req : assert property (@(posedge clk_i) disable iff (!arst_ni)
    gnt_addr_valid_o |-> req_i[gnt_addr_o])
    else $error("Grant to source %0d which has no request.", gnt_addr_o);

endmodule

`default_nettype wire

// File: source/src_latch.sv
// Source holding registers
`timescale 1ns/1ps
`default_nettype none

module src_latch
  import arb_pkg::*, pkt_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_ni,
  input  logic     [NUM_SRC-1:0]     strobe_i,     // One cycle load pulse per source.
  input  payload_t [NUM_SRC-1:0]     data_i,       // Payload offered by each source.
  input  src_idx_t                   gnt_addr_i,   // Source chosen by the arbiter.
  input  logic                       gnt_valid_i,  // Arbiter grant is issued.
  output logic     [NUM_SRC-1:0]     pending_o,    // Sources holding an ungranted payload.
  output payload_t                   gnt_data_o    // Payload of the granted source.
);

  logic     [NUM_SRC-1:0] pending_q;  // One pending flag per source.
  payload_t [NUM_SRC-1:0] data_q;     // Held payload per source.
  logic     [NUM_SRC-1:0] load;       // Strobe accepted on an idle source.
  logic     [NUM_SRC-1:0] clear;      // Pending flag dropped by a grant.

  // A strobe only counts when the source holds nothing, even if it is
  // being granted in the same cycle.
  assign load = strobe_i & ~pending_q;

  always_comb begin
    clear = '0;
    if (gnt_valid_i) begin
      clear[gnt_addr_i] = 1'b1;  // Exactly one source is released per grant.
    end
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear) | load;  // Load and clear never hit the same bit.
    end
  end

  // Payloads are only captured together with a fresh pending flag.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_SRC; i++) begin
      if (load[i]) begin
        data_q[i] <= data_i[i];
      end
    end
  end

  assign pending_o  = pending_q;           // Busy level seen by the sources.
  assign gnt_data_o = data_q[gnt_addr_i];  // Payload that goes into the record.

  // The arbiter is fed from pending_o, so a grant must name a pending source.
  a_gnt_pending : assert property (@(posedge clk_i) disable iff (!arst_ni)
    gnt_valid_i |-> pending_q[gnt_addr_i])
    else $error("Grant to idle source %0d.", gnt_addr_i);

endmodule

`default_nettype wire

// File: source/grant_fifo.sv
// Grant record FIFO
`timescale 1ns/1ps
`default_nettype none

module grant_fifo
  import pkt_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_ni,
  input  logic       push_i,    // Write wr_rec_i at the clock edge.
  input  grant_rec_t wr_rec_i,  // Record to store.
  input  logic       pop_i,     // Drop the head at the clock edge.
  output grant_rec_t rd_rec_o,  // Head record, valid while not empty.
  output logic       full_o,    // No room for another record.
  output logic       empty_o    // Nothing stored.
);

  grant_rec_t             mem [FIFO_DEPTH];  // Record storage.
  logic [FIFO_PTR_W-1:0]  wr_ptr;            // Next slot to write.
  logic [FIFO_PTR_W-1:0]  rd_ptr;            // Slot holding the head.
  logic [FIFO_PTR_W:0]    count;             // Records currently stored.
  logic                   push_ok;           // Push that is actually performed.
  logic                   pop_ok;            // Pop that is actually performed.

  assign full_o  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);

  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;  // Pops on an empty FIFO are dropped.

  // The head record is visible on the output without a pop.
  assign rd_rec_o = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        // Pointers wrap back to slot zero after the last entry.
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;  // Write only.
        2'b01:   count <= count - 1'b1;  // Read only.
        default: count <= count;         // Both or neither leave the level alone.
      endcase
    end
  end

  // Storage is written only on accepted pushes.
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= wr_rec_i;
    end
  end

  // The arbiter is held off by full_o, so a push into a full FIFO means lost data.
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_ni)
    push_i |-> !full_o)
    else $error("Push into a full FIFO.");

endmodule

`default_nettype wire

// File: source/req_merge_top.sv
// Request merger top level
`timescale 1ns/1ps
`default_nettype none

module req_merge_top
  import arb_pkg::*, pkt_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_ni,
  input  logic     [NUM_SRC-1:0] src_strobe_i,  // Payload strobes, one per source.
  input  payload_t [NUM_SRC-1:0] src_data_i,    // Payloads, one per source.
  output logic     [NUM_SRC-1:0] src_busy_o,    // Source still holds a payload.
  input  logic                   pop_i,         // Consumer takes the head record.
  output grant_rec_t             rd_rec_o,      // Head record.
  output logic                   full_o,        // FIFO is full.
  output logic                   empty_o        // FIFO is empty.
);

  src_idx_t   gnt_addr;   // Winning source.
  logic       gnt_valid;  // Grant issued this cycle and used as the FIFO push.
  payload_t   gnt_data;   // Payload of the winner.
  grant_rec_t push_rec;   // Record built for the FIFO.

  src_latch u_latch (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .strobe_i   (src_strobe_i),
    .data_i     (src_data_i),
    .gnt_addr_i (gnt_addr),
    .gnt_valid_i(gnt_valid),
    .pending_o  (src_busy_o),
    .gnt_data_o (gnt_data)
  );

  // Grants stop while the FIFO is full, so pending sources simply wait.
  round_robin_arbiter u_arb (
    .clk_i           (clk_i),
    .arst_ni         (arst_ni),
    .allow_req_i     (~full_o),
    .req_i           (src_busy_o),
    .gnt_addr_o      (gnt_addr),
    .gnt_addr_valid_o(gnt_valid)
  );

  assign push_rec = '{src: gnt_addr, payload: gnt_data};

  grant_fifo u_fifo (
    .clk_i   (clk_i),
    .arst_ni (arst_ni),
    .push_i  (gnt_valid),
    .wr_rec_i(push_rec),
    .pop_i   (pop_i),
    .rd_rec_o(rd_rec_o),
    .full_o  (full_o),
    .empty_o (empty_o)
  );

endmodule

`default_nettype wire

// File: test/tb_req_merge_top.sv
// Request merger testbench
`timescale 1ns/1ps
`default_nettype none

module tb_req_merge_top
  import arb_pkg::*, pkt_pkg::*;
();

  localparam int RAND_CYCLES = 200;              // Length of the random traffic test.
  localparam int MAX_CYCLES  = RAND_CYCLES + 200; // Directed tests stay well under 200 cycles.

  logic                   clk_i;
  logic                   arst_ni;
  logic     [NUM_SRC-1:0] src_strobe_i;
  payload_t [NUM_SRC-1:0] src_data_i;
  logic     [NUM_SRC-1:0] src_busy_o;
  logic                   pop_i;
  grant_rec_t             rd_rec_o;
  logic                   full_o;
  logic                   empty_o;

  integer seed = 32'h4eaab859;  // Fixed seed for repeatable payloads.
  int err_cnt = 0;              // Mismatches seen so far.
  int tests_ok = 0;
  int tests_bad = 0;
  int cycle_cnt = 0;

  logic     [NUM_SRC-1:0] m_pend;  // Model pending bits.
  payload_t [NUM_SRC-1:0] m_data;  // Model held payloads.
  src_idx_t               m_last;  // Model last granted source.
  grant_rec_t             m_q[$];  // Model FIFO contents with the head at index zero.
  int                     m_count; // Model occupancy.
  grant_rec_t             m_head;  // Model head record.

  req_merge_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period.
  end

  // Reference model of latch, round robin and FIFO, stepped on the same edges as the DUT.
  always @(posedge clk_i or negedge arst_ni) begin : ref_model
    logic found;
    src_idx_t win;
    src_idx_t idx;
    grant_rec_t rec;
    logic [NUM_SRC-1:0] nxt_pend;
    if (!arst_ni) begin
      m_pend = '0;
      m_last = src_idx_t'(NUM_SRC - 1);  // Source 0 goes first after reset.
      m_q.delete();
    end else begin
      found = 1'b0;
      win = '0;
      idx = m_last;
      if (m_q.size() < FIFO_DEPTH) begin  // Grants stop while the FIFO is full.
        for (int k = 0; k < NUM_SRC; k++) begin
          idx = (idx == src_idx_t'(NUM_SRC - 1)) ? '0 : idx + 1'b1;  // Count upward cyclically.
          if (!found && m_pend[idx]) begin
            found = 1'b1;
            win = idx;
          end
        end
      end
      if (pop_i && m_q.size() > 0) begin
        void'(m_q.pop_front());  // Pop on empty is ignored.
      end
      nxt_pend = m_pend;
      if (found) begin
        rec.src = win;
        rec.payload = m_data[win];
        m_q.push_back(rec);
        nxt_pend[win] = 1'b0;
        m_last = win;
      end
      for (int s = 0; s < NUM_SRC; s++) begin
        if (src_strobe_i[s] && !m_pend[s]) begin  // Strobe on a busy source is dropped.
          nxt_pend[s] = 1'b1;
          m_data[s] = src_data_i[s];
        end
      end
      m_pend = nxt_pend;
    end
    m_count = m_q.size();
    m_head = (m_count > 0) ? m_q[0] : '0;
  end

  task automatic report_error(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("ERR %s expected %0h got %0h at %0t", sig, exp_v, act_v, $time);
    err_cnt++;
  endtask

  task automatic check_value(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      report_error(sig, exp_v, act_v);
    end
  endtask

  // Outputs are compared on the falling edge, half a cycle away from any update.
  a_empty : assert property (@(negedge clk_i) disable iff (!arst_ni) empty_o == (m_count == 0))
    else report_error("empty_o", 32'(m_count == 0), 32'(empty_o));
  a_full : assert property (@(negedge clk_i) disable iff (!arst_ni)
    full_o == (m_count == FIFO_DEPTH))
    else report_error("full_o", 32'(m_count == FIFO_DEPTH), 32'(full_o));
  a_busy : assert property (@(negedge clk_i) disable iff (!arst_ni) src_busy_o == m_pend)
    else report_error("src_busy_o", 32'(m_pend), 32'(src_busy_o));
  a_head : assert property (@(negedge clk_i) disable iff (!arst_ni)
    (m_count != 0) |-> (rd_rec_o == m_head))
    else report_error("rd_rec_o", 32'(m_head), 32'(rd_rec_o));

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete.", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // Inputs change just after the edge.
  endtask

  task automatic apply_reset();
    src_strobe_i = '0;
    src_data_i = '0;
    pop_i = 1'b0;
    arst_ni = 1'b0;
    repeat (2) next_cycle();
    arst_ni = 1'b1;
  endtask

  function automatic payload_t rand_byte();
    return payload_t'($random(seed));
  endfunction

  task automatic strobe_sources(input logic [NUM_SRC-1:0] mask,
                                input payload_t [NUM_SRC-1:0] data);
    src_data_i = data;
    src_strobe_i = mask;
    next_cycle();
    src_strobe_i = '0;
  endtask

  task automatic wait_idle();
    while (src_busy_o != '0) next_cycle();  // One grant per cycle drains the sources.
  endtask

  // Checks the head record and then removes it.
  task automatic pop_expect(input int src, input payload_t pl);
    check_value("empty_o", 32'(1'b0), 32'(empty_o));
    check_value("rd_rec_o.src", 32'(src), 32'(rd_rec_o.src));
    check_value("rd_rec_o.payload", 32'(pl), 32'(rd_rec_o.payload));
    pop_i = 1'b1;
    next_cycle();
    pop_i = 1'b0;
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_ok++;
      $display("PASS %s", name);
    end else begin
      tests_bad++;
      $display("FAIL %s, %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  initial begin : stimulus
    int errs;
    payload_t [NUM_SRC-1:0] d0;
    payload_t [NUM_SRC-1:0] d1;
    payload_t [NUM_SRC-1:0] d2;
    apply_reset();
    errs = err_cnt;
    check_value("empty_o", 32'(1'b1), 32'(empty_o));
    check_value("full_o", 32'(1'b0), 32'(full_o));
    check_value("src_busy_o", 32'(0), 32'(src_busy_o));
    close_test("reset state", errs);

    errs = err_cnt;
    d0 = '0;
    d0[2] = rand_byte();
    strobe_sources(4'b0100, d0);
    check_value("src_busy_o[2]", 32'(1'b1), 32'(src_busy_o[2]));
    next_cycle();                                 // Record lands one edge later.
    pop_expect(2, d0[2]);
    close_test("single strobe", errs);

    errs = err_cnt;
    apply_reset();
    for (int s = 0; s < NUM_SRC; s++) begin
      d0[s] = rand_byte();
      d1[s] = rand_byte();
      d2[s] = rand_byte();
    end
    strobe_sources(4'b1111, d0);
    wait_idle();
    for (int s = 0; s < NUM_SRC; s++) pop_expect(s, d0[s]);
    strobe_sources(4'b0011, d1);                  // Grant history now ends at source 1.
    wait_idle();
    pop_expect(0, d1[0]);
    pop_expect(1, d1[1]);
    strobe_sources(4'b1111, d2);
    wait_idle();
    for (int s = 2; s < NUM_SRC + 2; s++) pop_expect(s % NUM_SRC, d2[s % NUM_SRC]);
    close_test("burst order", errs);

    errs = err_cnt;
    d0[1] = rand_byte();
    d1[1] = ~d0[1];                               // Second payload always differs.
    strobe_sources(4'b0010, d0);
    strobe_sources(4'b0010, d1);                  // Arrives while busy and being granted.
    wait_idle();
    pop_expect(1, d0[1]);
    check_value("empty_o", 32'(1'b1), 32'(empty_o));
    close_test("busy strobe ignored", errs);

    errs = err_cnt;
    apply_reset();
    strobe_sources(4'b1111, d0);
    wait_idle();
    strobe_sources(4'b1111, d1);
    wait_idle();
    check_value("full_o", 32'(1'b1), 32'(full_o));
    strobe_sources(4'b1111, d2);
    repeat (2) next_cycle();                      // Sources must hold while the FIFO is full.
    check_value("src_busy_o", 32'(4'b1111), 32'(src_busy_o));
    for (int s = 0; s < NUM_SRC; s++) pop_expect(s, d0[s]);
    for (int s = 0; s < NUM_SRC; s++) pop_expect(s, d1[s]);
    for (int s = 0; s < NUM_SRC; s++) pop_expect(s, d2[s]);
    check_value("empty_o", 32'(1'b1), 32'(empty_o));
    close_test("back pressure", errs);

    errs = err_cnt;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      for (int s = 0; s < NUM_SRC; s++) src_data_i[s] = rand_byte();
      if (i < RAND_CYCLES / 2) begin              // Heavy load first, so the FIFO fills.
        src_strobe_i = NUM_SRC'($random(seed));
        pop_i = (($random(seed) & 3) == 0);
      end else begin                              // Then light load, so it drains.
        src_strobe_i = NUM_SRC'($random(seed)) & NUM_SRC'($random(seed));
        pop_i = (($random(seed) & 3) != 0);
      end
      next_cycle();
    end
    src_strobe_i = '0;
    while (!empty_o || src_busy_o != '0) begin
      pop_i = 1'b1;
      next_cycle();
    end
    pop_i = 1'b0;
    close_test("random traffic", errs);

    $display("Tests passed %0d, failed %0d, mismatches %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/arb_pkg.sv
source/pkt_pkg.sv
source/circular_xbar.sv
source/fixed_priority_arbiter.sv
source/round_robin_arbiter.sv
source/src_latch.sv
source/grant_fifo.sv
source/req_merge_top.sv
test/tb_req_merge_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_req_merge_top -f compile.f -o tb_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned a failing status." >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
